// File: cnn_pkg.sv
package cnn_pkg;

  //////////////////////////////////////////////////////////////////////
  // Register map of the AXI4-Lite slave
  //////////////////////////////////////////////////////////////////////

  // Byte offsets in the 4-bit address space
  typedef enum logic [3:0] {
    // Bit 0 enable, bit 1 write-one status clear
    REG_CTRL   = 4'h0,
    // Leaky shift in bits 2..0
    REG_LEAKY  = 4'h4,
    // Signed Q8.8 scale in bits 15..0
    REG_SCALE  = 4'h8,
    // Bit 0 sticky FIFO overflow, read only
    REG_STATUS = 4'hC
  } reg_addr_e;

  // AXI response codes in use
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

  //////////////////////////////////////////////////////////////////////
  // Fixed-point constants
  //////////////////////////////////////////////////////////////////////

  // Scale is Q8.8
  localparam int SCALE_WIDTH     = 16;
  localparam int SCALE_FRAC_BITS = 8;

  // Leaky shift amount, 0..7
  localparam int SHIFT_WIDTH     = 3;

endpackage

// File: cnn_csr_axil.sv
`timescale 1ns/1ps

module cnn_csr_axil import cnn_pkg::*; (
  input  logic                          clk,
  input  logic                          reset,
  // Write address and data
  input  logic [3:0]                    s_awaddr,
  input  logic                          s_awvalid,
  output logic                          s_awready,
  input  logic [31:0]                   s_wdata,
  input  logic [3:0]                    s_wstrb,
  input  logic                          s_wvalid,
  output logic                          s_wready,
  // Write response
  output logic [1:0]                    s_bresp,
  output logic                          s_bvalid,
  input  logic                          s_bready,
  // Read address and data
  input  logic [3:0]                    s_araddr,
  input  logic                          s_arvalid,
  output logic                          s_arready,
  output logic [31:0]                   s_rdata,
  output logic [1:0]                    s_rresp,
  output logic                          s_rvalid,
  input  logic                          s_rready,
  // Datapath side
  input  logic                          fifo_overflow,
  output logic                          enable,
  output logic [SHIFT_WIDTH-1:0]        leaky_shift,
  output logic signed [SCALE_WIDTH-1:0] scale,
  output logic                          status_clear
);

  typedef enum logic [1:0] {W_IDLE, W_ACCEPT, W_RESP} wr_state_e;
  typedef enum logic [1:0] {R_IDLE, R_ACCEPT, R_RESP} rd_state_e;

  wr_state_e   wr_state;
  rd_state_e   rd_state;
  logic [31:0] wr_cur;
  logic [31:0] wr_merge;

  // Byte-lane merge of write data into the current word
  function automatic logic [31:0] apply_strb(input logic [31:0] cur,
                                             input logic [31:0] wd,
                                             input logic [3:0]  strb);
    logic [31:0] res;
    res = cur;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        res[i*8 +: 8] = wd[i*8 +: 8];
      end
    end
    return res;
  endfunction

  // Current contents of the addressed register, seen as a 32-bit word
  always_comb begin
    case (reg_addr_e'(s_awaddr))
      REG_CTRL:  wr_cur = {31'd0, enable};
      REG_LEAKY: wr_cur = {{(32-SHIFT_WIDTH){1'b0}}, leaky_shift};
      REG_SCALE: wr_cur = {{(32-SCALE_WIDTH){1'b0}}, scale};
      default:   wr_cur = 32'd0;
    endcase
  end

  // Clear bit of CTRL always reads back as 0, so it only pulses on a 1
  assign wr_merge = apply_strb(wr_cur, s_wdata, s_wstrb);

  //////////////////////////////////////////////////////////////////////
  // Write channel
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_state     <= W_IDLE;
      s_awready    <= 1'b0;
      s_wready     <= 1'b0;
      s_bvalid     <= 1'b0;
      s_bresp      <= RESP_OKAY;
      enable       <= 1'b0;
      leaky_shift  <= '0;
      scale        <= '0;
      status_clear <= 1'b0;
    end else begin
      status_clear <= 1'b0;
      case (wr_state)
        W_IDLE: begin
          // Address and data taken together, one response at a time
          if (s_awvalid && s_wvalid) begin
            s_awready <= 1'b1;
            s_wready  <= 1'b1;
            wr_state  <= W_ACCEPT;
          end
        end
        W_ACCEPT: begin
          // Handshake completes in this cycle
          s_awready <= 1'b0;
          s_wready  <= 1'b0;
          s_bvalid  <= 1'b1;
          s_bresp   <= RESP_OKAY;
          wr_state  <= W_RESP;
          case (reg_addr_e'(s_awaddr))
            REG_CTRL: begin
              enable       <= wr_merge[0];
              status_clear <= wr_merge[1];
            end
            REG_LEAKY: leaky_shift <= wr_merge[SHIFT_WIDTH-1:0];
            REG_SCALE: scale       <= wr_merge[SCALE_WIDTH-1:0];
            // Status is read only
            REG_STATUS: s_bresp <= RESP_SLVERR;
            default:    s_bresp <= RESP_SLVERR;
          endcase
        end
        W_RESP: begin
          // Hold response until the master takes it
          if (s_bready) begin
            s_bvalid <= 1'b0;
            wr_state <= W_IDLE;
          end
        end
        default: wr_state <= W_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read channel
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_state  <= R_IDLE;
      s_arready <= 1'b0;
      s_rvalid  <= 1'b0;
      s_rresp   <= RESP_OKAY;
      s_rdata   <= 32'd0;
    end else begin
      case (rd_state)
        R_IDLE: begin
          if (s_arvalid) begin
            s_arready <= 1'b1;
            rd_state  <= R_ACCEPT;
          end
        end
        R_ACCEPT: begin
          s_arready <= 1'b0;
          s_rvalid  <= 1'b1;
          s_rresp   <= RESP_OKAY;
          rd_state  <= R_RESP;
          case (reg_addr_e'(s_araddr))
            REG_CTRL:   s_rdata <= {31'd0, enable};
            REG_LEAKY:  s_rdata <= {{(32-SHIFT_WIDTH){1'b0}}, leaky_shift};
            // Scale reads back zero-extended
            REG_SCALE:  s_rdata <= {{(32-SCALE_WIDTH){1'b0}}, scale};
            REG_STATUS: s_rdata <= {31'd0, fifo_overflow};
            default: begin
              s_rdata <= 32'd0;
              s_rresp <= RESP_SLVERR;
            end
          endcase
        end
        R_RESP: begin
          if (s_rready) begin
            s_rvalid <= 1'b0;
            rd_state <= R_IDLE;
          end
        end
        default: rd_state <= R_IDLE;
      endcase
    end
  end

endmodule

// File: line_buffer.sv
`timescale 1ns/1ps

module line_buffer #(
  parameter int DEPTH     = 64,
  parameter int DIN_WIDTH = 16
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 wr_en,
  input  logic [DIN_WIDTH-1:0] data_in,
  input  logic                 rd_en,
  input  logic                 status_clear,
  output logic [DIN_WIDTH-1:0] data_out,
  output logic                 valid_out,
  output logic                 empty,
  output logic                 overflow
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [DIN_WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0]     wr_ptr;
  logic [PTR_W-1:0]     rd_ptr;
  logic [CNT_W-1:0]     count;
  logic                 full;
  logic                 do_wr;
  logic                 do_rd;

  assign empty = (count == '0);
  assign full  = (count == CNT_W'(DEPTH));
  // Writes into a full buffer are lost
  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  // Storage and read data, no reset
  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= data_in;
    end
    if (do_rd) begin
      data_out <= mem[rd_ptr];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Pointers, count, status
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      valid_out <= 1'b0;
      overflow  <= 1'b0;
    end else begin
      // Read data valid one cycle after the read
      valid_out <= do_rd;
      if (do_wr) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(do_wr) - CNT_W'(do_rd);
      // Sticky until cleared from the CSR block
      if (status_clear) begin
        overflow <= 1'b0;
      end else if (wr_en && full) begin
        overflow <= 1'b1;
      end
    end
  end

endmodule

// File: cnn_leaky_relu.sv
`timescale 1ns/1ps

module cnn_leaky_relu import cnn_pkg::*; #(
  parameter int DATA_WIDTH = 16
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         valid_in,
  input  logic signed [DATA_WIDTH-1:0] data_in,
  input  logic [SHIFT_WIDTH-1:0]       leaky_shift,
  output logic                         valid_out,
  output logic signed [DATA_WIDTH-1:0] data_out
);

  logic signed [DATA_WIDTH-1:0] relu;

  // Negative slope of 2^-leaky_shift
  always_comb begin
    if (data_in[DATA_WIDTH-1]) begin
      relu = data_in >>> leaky_shift;
    end else begin
      relu = data_in;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Output stage, single cycle
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_out <= 1'b0;
    end else begin
      valid_out <= valid_in;
    end
  end

  // Pixel register
  always_ff @(posedge clk) begin
    if (valid_in) begin
      data_out <= relu;
    end
  end

endmodule

// File: cnn_pointwise_scale.sv
`timescale 1ns/1ps

module cnn_pointwise_scale import cnn_pkg::*; #(
  parameter int DATA_WIDTH = 16
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          valid_in,
  input  logic signed [DATA_WIDTH-1:0]  data_in,
  input  logic signed [SCALE_WIDTH-1:0] scale,
  output logic                          valid_out,
  output logic signed [DATA_WIDTH-1:0]  data_out
);

  // One guard bit above the full product
  localparam int PROD_W = DATA_WIDTH + SCALE_WIDTH + 1;

  localparam logic signed [PROD_W-1:0] ROUND_HALF = 1 << (SCALE_FRAC_BITS - 1);
  localparam logic signed [PROD_W-1:0] SAT_MAX =
    {{(PROD_W - DATA_WIDTH + 1){1'b0}}, {(DATA_WIDTH - 1){1'b1}}};
  localparam logic signed [PROD_W-1:0] SAT_MIN =
    {{(PROD_W - DATA_WIDTH + 1){1'b1}}, {(DATA_WIDTH - 1){1'b0}}};

  logic signed [PROD_W-1:0] prod;
  logic signed [PROD_W-1:0] rounded;
  logic signed [PROD_W-1:0] shifted;
  logic signed [PROD_W-1:0] sat;

  // Full-width product, then round half up
  always_comb begin
    prod    = data_in * scale;
    rounded = prod + ROUND_HALF;
    shifted = rounded >>> SCALE_FRAC_BITS;
    // Clamp to the pixel range
    if (shifted > SAT_MAX) begin
      sat = SAT_MAX;
    end else if (shifted < SAT_MIN) begin
      sat = SAT_MIN;
    end else begin
      sat = shifted;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_out <= 1'b0;
    end else begin
      valid_out <= valid_in;
    end
  end

  always_ff @(posedge clk) begin
    if (valid_in) begin
      data_out <= sat[DATA_WIDTH-1:0];
    end
  end

endmodule

// File: cnn_concat_2in.sv
`timescale 1ns/1ps

module cnn_concat_2in #(
  parameter int DATA_WIDTH = 16
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         valid_in_no1,
  input  logic signed [DATA_WIDTH-1:0] in_no1,
  input  logic                         fifo_empty,
  input  logic                         fifo_valid,
  input  logic signed [DATA_WIDTH-1:0] fifo_data,
  output logic                         fifo_rd,
  output logic signed [DATA_WIDTH-1:0] out,
  output logic                         valid_out,
  output logic                         out_channel
);

  logic                         skid_valid;
  logic signed [DATA_WIDTH-1:0] skid_data;
  logic                         in_flight;
  logic                         fwd_fifo;

  // A returned FIFO pixel goes out only when branch one is idle
  assign fwd_fifo = !valid_in_no1 && (skid_valid || fifo_valid);
  // Next read only once the previous pixel is leaving this cycle
  assign fifo_rd  = !valid_in_no1 && !fifo_empty && (!in_flight || fwd_fifo);

  //////////////////////////////////////////////////////////////////////
  // Control, branch one first
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_out   <= 1'b0;
      out_channel <= 1'b0;
      skid_valid  <= 1'b0;
      in_flight   <= 1'b0;
    end else begin
      valid_out   <= valid_in_no1 || fwd_fifo;
      out_channel <= fwd_fifo;
      // FIFO data landing on a busy branch-one cycle waits in the skid
      if (valid_in_no1 && fifo_valid) begin
        skid_valid <= 1'b1;
      end else if (!valid_in_no1) begin
        skid_valid <= 1'b0;
      end
      if (fifo_rd) begin
        in_flight <= 1'b1;
      end else if (fwd_fifo) begin
        in_flight <= 1'b0;
      end
    end
  end

  // Output mux and skid data
  always_ff @(posedge clk) begin
    if (valid_in_no1) begin
      out <= in_no1;
    end else if (skid_valid) begin
      out <= skid_data;
    end else if (fifo_valid) begin
      out <= fifo_data;
    end
    if (valid_in_no1 && fifo_valid) begin
      skid_data <= fifo_data;
    end
  end

endmodule

// File: cnn_route_top.sv
`timescale 1ns/1ps

module cnn_route_top import cnn_pkg::*; #(
  parameter int DATA_WIDTH   = 16,
  parameter int FRAME_PIXELS = 64
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [3:0]                   s_awaddr,
  input  logic                         s_awvalid,
  output logic                         s_awready,
  input  logic [31:0]                  s_wdata,
  input  logic [3:0]                   s_wstrb,
  input  logic                         s_wvalid,
  output logic                         s_wready,
  output logic [1:0]                   s_bresp,
  output logic                         s_bvalid,
  input  logic                         s_bready,
  input  logic [3:0]                   s_araddr,
  input  logic                         s_arvalid,
  output logic                         s_arready,
  output logic [31:0]                  s_rdata,
  output logic [1:0]                   s_rresp,
  output logic                         s_rvalid,
  input  logic                         s_rready,
  input  logic                         pix_valid,
  input  logic signed [DATA_WIDTH-1:0] pix_data,
  output logic                         out_valid,
  output logic signed [DATA_WIDTH-1:0] out_data,
  output logic                         out_channel
);

  logic                         enable;
  logic [SHIFT_WIDTH-1:0]       leaky_shift;
  logic signed [SCALE_WIDTH-1:0] scale;
  logic                         status_clear;
  logic                         fifo_overflow;
  logic                         pix_gated;
  // Branch outputs
  logic                         relu_valid;
  logic signed [DATA_WIDTH-1:0] relu_data;
  logic                         scale_valid;
  logic signed [DATA_WIDTH-1:0] scale_data;
  // FIFO to concat
  logic                         fifo_rd;
  logic                         fifo_empty;
  logic                         fifo_valid;
  logic [DATA_WIDTH-1:0]        fifo_data;

  // Pixels dropped while disabled
  assign pix_gated = pix_valid && enable;

  cnn_csr_axil u_csr (
    .clk, .reset,
    .s_awaddr, .s_awvalid, .s_awready, .s_wdata, .s_wstrb, .s_wvalid, .s_wready,
    .s_bresp, .s_bvalid, .s_bready,
    .s_araddr, .s_arvalid, .s_arready, .s_rdata, .s_rresp, .s_rvalid, .s_rready,
    .fifo_overflow, .enable, .leaky_shift, .scale, .status_clear
  );

  //////////////////////////////////////////////////////////////////////
  // Branches, both one cycle
  //////////////////////////////////////////////////////////////////////

  cnn_leaky_relu #(.DATA_WIDTH(DATA_WIDTH)) u_relu (
    .clk, .reset,
    .valid_in (pix_gated),  .data_in  (pix_data), .leaky_shift,
    .valid_out(relu_valid), .data_out (relu_data)
  );

  cnn_pointwise_scale #(.DATA_WIDTH(DATA_WIDTH)) u_scale (
    .clk, .reset,
    .valid_in (pix_gated),   .data_in  (pix_data), .scale,
    .valid_out(scale_valid), .data_out (scale_data)
  );

  // Branch two waits here for branch-one idle cycles
  line_buffer #(.DEPTH(FRAME_PIXELS), .DIN_WIDTH(DATA_WIDTH)) u_line_buffer (
    .clk, .reset,
    .wr_en   (scale_valid), .data_in  (scale_data),
    .rd_en   (fifo_rd),     .status_clear,
    .data_out(fifo_data),   .valid_out(fifo_valid),
    .empty   (fifo_empty),  .overflow (fifo_overflow)
  );

  cnn_concat_2in #(.DATA_WIDTH(DATA_WIDTH)) u_concat (
    .clk, .reset,
    .valid_in_no1(relu_valid), .in_no1   (relu_data),
    .fifo_empty, .fifo_valid,  .fifo_data(fifo_data), .fifo_rd,
    .out         (out_data),   .valid_out(out_valid), .out_channel
  );

endmodule

// File: tb_cnn_route_top.sv
`timescale 1ns/1ps

module tb_cnn_route_top import cnn_pkg::*;;

  localparam int DATA_WIDTH      = 16;
  localparam int FRAME_PIXELS    = 64;
  // Four enabled frames, one disabled frame, one back-to-back pair
  localparam int NUM_FRAMES      = 7;
  localparam int WATCHDOG_CYCLES = NUM_FRAMES * 3 * FRAME_PIXELS + 2000;
  localparam longint PIX_MAX     = longint'(2 ** (DATA_WIDTH - 1)) - 1;
  localparam longint PIX_MIN     = -PIX_MAX - 1;

  logic                         clk;
  logic                         reset;
  logic [3:0]                   s_awaddr;
  logic                         s_awvalid;
  logic                         s_awready;
  logic [31:0]                  s_wdata;
  logic [3:0]                   s_wstrb;
  logic                         s_wvalid;
  logic                         s_wready;
  logic [1:0]                   s_bresp;
  logic                         s_bvalid;
  logic                         s_bready;
  logic [3:0]                   s_araddr;
  logic                         s_arvalid;
  logic                         s_arready;
  logic [31:0]                  s_rdata;
  logic [1:0]                   s_rresp;
  logic                         s_rvalid;
  logic                         s_rready;
  logic                         pix_valid;
  logic signed [DATA_WIDTH-1:0] pix_data;
  logic                         out_valid;
  logic signed [DATA_WIDTH-1:0] out_data;
  logic                         out_channel;

  // Model state, written on clock edges only
  logic                          en_model;
  logic                          check_on;
  logic [SHIFT_WIDTH-1:0]        shift_model;
  logic signed [SCALE_WIDTH-1:0] scale_model;
  logic signed [DATA_WIDTH-1:0]  exp0_q[$];
  logic signed [DATA_WIDTH-1:0]  exp1_q[$];
  logic signed [DATA_WIDTH-1:0]  exp_pix;
  logic                          pv_d1;
  logic                          pv_d2;
  logic [31:0]                   seed;
  int                            cnt0;
  int                            cnt1;
  int                            checks;
  int                            errors;

  cnn_route_top #(.DATA_WIDTH(DATA_WIDTH), .FRAME_PIXELS(FRAME_PIXELS)) u_dut (.*);

  always #10 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Reference rules and stimulus helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Negative pixels scaled by 2^-sh
  function automatic logic signed [DATA_WIDTH-1:0] leaky_ref(
      input logic signed [DATA_WIDTH-1:0] x, input logic [SHIFT_WIDTH-1:0] sh);
    if (x < 0) begin
      return x >>> sh;
    end
    return x;
  endfunction

  // Q8.8 multiply, round half up, clamp
  function automatic logic signed [DATA_WIDTH-1:0] scale_ref(
      input logic signed [DATA_WIDTH-1:0] x, input logic signed [SCALE_WIDTH-1:0] s);
    longint p;
    p = longint'(x) * longint'(s);
    p = p + (longint'(1) << (SCALE_FRAC_BITS - 1));
    p = p >>> SCALE_FRAC_BITS;
    if (p > PIX_MAX) begin
      p = PIX_MAX;
    end else if (p < PIX_MIN) begin
      p = PIX_MIN;
    end
    return DATA_WIDTH'(p);
  endfunction

  // Extremes open every frame, random pixels after
  function automatic logic signed [DATA_WIDTH-1:0] pick_pixel(input int idx);
    seed = lcg_next(seed);
    case (idx)
      0:       return {1'b1, {(DATA_WIDTH - 1){1'b0}}};
      1:       return {1'b0, {(DATA_WIDTH - 1){1'b1}}};
      2:       return '1;
      default: return seed[23:8];
    endcase
  endfunction

  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    @(posedge clk);
    s_awaddr  <= addr;
    s_awvalid <= 1'b1;
    s_wdata   <= data;
    s_wstrb   <= 4'hF;
    s_wvalid  <= 1'b1;
    do @(posedge clk); while (!(s_awready && s_wready));
    s_awvalid <= 1'b0;
    s_wvalid  <= 1'b0;
    do @(posedge clk); while (!s_bvalid);
    resp = s_bresp;
  endtask

  task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    @(posedge clk);
    s_araddr  <= addr;
    s_arvalid <= 1'b1;
    do @(posedge clk); while (!s_arready);
    s_arvalid <= 1'b0;
    do @(posedge clk); while (!s_rvalid);
    data = s_rdata;
    resp = s_rresp;
  endtask

  task automatic write_ctrl(input logic [31:0] data);
    logic [1:0] resp;
    axi_write(REG_CTRL, data, resp);
    expect_eq("s_bresp CTRL", 32'(resp), 32'(RESP_OKAY));
  endtask

  // Program shift and scale, read both back
  task automatic configure(input logic [SHIFT_WIDTH-1:0] sh, input logic [15:0] sc);
    logic [1:0]  resp;
    logic [31:0] rd;
    axi_write(REG_LEAKY, 32'(sh), resp);
    expect_eq("s_bresp LEAKY", 32'(resp), 32'(RESP_OKAY));
    axi_read(REG_LEAKY, rd, resp);
    expect_eq("s_rdata LEAKY", rd, 32'(sh));
    expect_eq("s_rresp LEAKY", 32'(resp), 32'(RESP_OKAY));
    axi_write(REG_SCALE, 32'(sc), resp);
    expect_eq("s_bresp SCALE", 32'(resp), 32'(RESP_OKAY));
    axi_read(REG_SCALE, rd, resp);
    expect_eq("s_rdata SCALE", rd, 32'(sc));
    expect_eq("s_rresp SCALE", 32'(resp), 32'(RESP_OKAY));
    shift_model <= sh;
    scale_model <= sc;
  endtask

  task automatic send_pixels(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      pix_valid <= 1'b1;
      pix_data  <= pick_pixel(i % FRAME_PIXELS);
    end
    @(posedge clk);
    pix_valid <= 1'b0;
  endtask

  // One frame plus the inter-frame gap, then per-channel counts
  task automatic run_frame(input bit expect_out);
    int c0;
    int c1;
    c0 = cnt0;
    c1 = cnt1;
    send_pixels(FRAME_PIXELS);
    repeat (FRAME_PIXELS + 6) @(posedge clk);
    expect_eq("ch0 count", cnt0 - c0, expect_out ? FRAME_PIXELS : 0);
    expect_eq("ch1 count", cnt1 - c1, expect_out ? FRAME_PIXELS : 0);
    expect_eq("ch1 pending", exp1_q.size(), 0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Output monitor
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (reset) begin
      pv_d1 = 1'b0;
      pv_d2 = 1'b0;
    end else begin
      if (check_on) begin
        // Channel 0 lands two cycles after its pixel
        if (pv_d2) begin
          checks++;
          assert (out_valid && !out_channel) else begin
            errors++;
            $display("channel 0 output missing two cycles after its input pixel");
          end
        end
        if (out_valid && !out_channel) begin
          cnt0++;
          checks++;
          assert (pv_d2 && exp0_q.size() > 0) else begin
            errors++;
            $display("channel 0 output with no input pixel two cycles earlier");
          end
          if (exp0_q.size() > 0) begin
            exp_pix = exp0_q.pop_front();
            expect_eq("out_data ch0", 32'(out_data), 32'(exp_pix));
          end
        end
        if (out_valid && out_channel) begin
          cnt1++;
          checks++;
          assert (exp1_q.size() > 0) else begin
            errors++;
            $display("channel 1 output while no scaled pixel is pending");
          end
          if (exp1_q.size() > 0) begin
            exp_pix = exp1_q.pop_front();
            expect_eq("out_data ch1", 32'(out_data), 32'(exp_pix));
          end
        end
      end
      pv_d2 = pv_d1;
      pv_d1 = pix_valid && en_model;
      if (check_on && pix_valid && en_model) begin
        exp0_q.push_back(leaky_ref(pix_data, shift_model));
        exp1_q.push_back(scale_ref(pix_data, scale_model));
      end
    end
  end

  // Hang guard
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: run exceeded %0d cycles", WATCHDOG_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    logic [1:0]  resp;
    logic [31:0] rd;
    clk         = 1'b0;
    reset       = 1'b1;
    s_awaddr    = '0;
    s_awvalid   = 1'b0;
    s_wdata     = '0;
    s_wstrb     = '0;
    s_wvalid    = 1'b0;
    s_bready    = 1'b1;
    s_araddr    = '0;
    s_arvalid   = 1'b0;
    s_rready    = 1'b1;
    pix_valid   = 1'b0;
    pix_data    = '0;
    en_model    = 1'b0;
    check_on    = 1'b0;
    shift_model = '0;
    scale_model = '0;
    seed        = 32'h5dc1_4e88;
    cnt0        = 0;
    cnt1        = 0;
    checks      = 0;
    errors      = 0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;

    // Unmapped addresses
    axi_read(4'h2, rd, resp);
    expect_eq("s_rresp unmapped", 32'(resp), 32'(RESP_SLVERR));
    expect_eq("s_rdata unmapped", rd, 32'd0);
    axi_write(4'h6, 32'h1234, resp);
    expect_eq("s_bresp unmapped", 32'(resp), 32'(RESP_SLVERR));

    // Enabled frames, saturation in both directions at the end
    configure(3'd3, 16'h0180);
    write_ctrl(32'h1);
    en_model <= 1'b1;
    check_on <= 1'b1;
    run_frame(1'b1);
    seed = lcg_next(seed);
    configure(seed[2:0], seed[31:16]);
    run_frame(1'b1);
    configure(3'd7, 16'h7FFF);
    run_frame(1'b1);
    configure(3'd0, 16'h8000);
    run_frame(1'b1);

    // Disabled, nothing may come out
    write_ctrl(32'h0);
    en_model <= 1'b0;
    run_frame(1'b0);

    // Back-to-back frames overrun the FIFO
    write_ctrl(32'h1);
    check_on <= 1'b0;
    send_pixels(2 * FRAME_PIXELS);
    repeat (2 * FRAME_PIXELS) @(posedge clk);
    axi_read(REG_STATUS, rd, resp);
    expect_eq("s_rdata STATUS set", rd, 32'd1);
    write_ctrl(32'h3);
    axi_read(REG_STATUS, rd, resp);
    expect_eq("s_rdata STATUS cleared", rd, 32'd0);
    expect_eq("s_rresp STATUS", 32'(resp), 32'(RESP_OKAY));

    repeat (10) @(posedge clk);
    $display("checks: %0d errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: cnn_route_top.f
cnn_pkg.sv
cnn_csr_axil.sv
line_buffer.sv
cnn_leaky_relu.sv
cnn_pointwise_scale.sv
cnn_concat_2in.sv
cnn_route_top.sv
tb_cnn_route_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps \
  --top-module tb_cnn_route_top \
  -f cnn_route_top.f

./obj_dir/Vtb_cnn_route_top > sim.log 2>&1
cat sim.log

if grep -q "^RESULT: PASS$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
